// ==== vfb_top.f ====
hw/vfb_geom_pkg.sv
hw/vfb_coef_pkg.sv
hw/column_if.sv
hw/line_delay.sv
hw/column_window.sv
hw/fltr_kernel.sv
hw/vfb_top.sv
sim/tb_vfb_top.sv

// ==== Makefile ====
# Verilator build for the vertical filter bank

TOP = tb_vfb_top
LOG = sim.log

.PHONY: run lint clean

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vfb_top.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^all tests passed$$" $(LOG) && echo "simulation ok" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing --top-module vfb_top -f vfb_top.f

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/tb_vfb_top.sv ====
module tb_vfb_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int LINE_LEN   = 8;
	localparam int TAPS       = vfb_geom_pkg::TAPS;
	localparam int NK         = vfb_coef_pkg::NUM_KERNELS;
	localparam int FILL       = TAPS * LINE_LEN;
	localparam int MAX_CYCLES = 2000;

	logic                           clk;
	logic                           rst_n;
	logic                           new_data;
	logic [vfb_geom_pkg::PIX_W-1:0] pix_in;
	logic                           out_valid;
	logic [vfb_coef_pkg::RES_W-1:0] res [NK];

	// reference model state
	int    hist [$];
	int    accept_cyc [$];
	int    exp_due [$];
	int    exp_val [$];
	int    cycle;
	int    errors;
	int    checks;
	int    results_seen;
	int    first_valid;
	int    tests_run;
	int    tests_ok;
	string res_name [NK] = '{"res_f1", "res_f2", "res_f3", "res_h1", "res_h2", "res_h3", "res_h4"};

	vfb_top #(
		.LINE_LENGTH(LINE_LEN)
	) dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.new_data (new_data),
		.pix_in   (pix_in),
		.out_valid(out_valid),
		.res_f1   (res[0]),
		.res_f2   (res[1]),
		.res_f3   (res[2]),
		.res_h1   (res[3]),
		.res_h2   (res[4]),
		.res_h3   (res[5]),
		.res_h4   (res[6])
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// row k of pixel n is pixel n-(k+1)*LINE_LEN
	function automatic void record_pixel(int p);
		int n;
		int acc;
		n = hist.size();
		hist.push_back(p);
		accept_cyc.push_back(cycle);
		if (n >= FILL)
		begin
			// high during the third cycle after the accepting edge
			exp_due.push_back(cycle + 2);
			for (int k = 0; k < NK; k++)
			begin
				acc = 0;
				for (int t = 0; t < TAPS; t++)
				begin
					acc += hist[n - (t + 1) * LINE_LEN] *
						int'(vfb_coef_pkg::KERNEL_COEF[k][t]);
				end
				exp_val.push_back(acc);
			end
		end
	endfunction

	function automatic void compare_results();
		int got;
		for (int k = 0; k < NK; k++)
		begin
			got = int'(res[k]);
			checks++;
			if (got != exp_val[0])
			begin
				$display("CHECK FAILED at %0t: %s expected %0d got %0d",
					$time, res_name[k], exp_val[0], got);
				errors++;
			end
			void'(exp_val.pop_front());
		end
		void'(exp_due.pop_front());
		results_seen++;
	endfunction

	function automatic int coef_sum(int k);
		int s;
		s = 0;
		for (int t = 0; t < TAPS; t++)
		begin
			s += int'(vfb_coef_pkg::KERNEL_COEF[k][t]);
		end
		return s;
	endfunction

	// inputs are stable at the rising edge, so accepted pixels are taken here
	always @(posedge clk)
	begin
		cycle = cycle + 1;
		if (cycle >= MAX_CYCLES)
		begin
			$display("run stopped by timeout after %0d cycles", cycle);
			$display("tests failed");
			$finish;
		end
		else if (rst_n && new_data)
		begin
			record_pixel(int'(pix_in));
		end
	end

	// outputs are compared away from the rising edge
	always @(negedge clk)
	begin
		if (rst_n && out_valid)
		begin
			if (first_valid < 0)
			begin
				first_valid = cycle;
			end
			if (exp_due.size() == 0)
			begin
				$display("at %0t: out_valid pulse with no pixel waiting for it", $time);
				errors++;
			end
			else
			begin
				if (exp_due[0] != cycle)
				begin
					$display("at %0t: out_valid in cycle %0d, expected in cycle %0d",
						$time, cycle, exp_due[0]);
					errors++;
				end
				compare_results();
			end
		end
		else if (rst_n && exp_due.size() > 0 && exp_due[0] == cycle)
		begin
			$display("at %0t: out_valid missing for the result due in cycle %0d",
				$time, cycle);
			errors++;
			repeat (NK) void'(exp_val.pop_front());
			void'(exp_due.pop_front());
		end
	end

	task automatic drive_pixel(int v);
		@(negedge clk);
		new_data = 1'b1;
		pix_in   = 8'(v);
	endtask

	task automatic drive_idle(int n);
		repeat (n)
		begin
			@(negedge clk);
			new_data = 1'b0;
		end
	endtask

	// let the kernel pipeline empty, then watch for stray pulses
	task automatic wait_drain();
		drive_idle(1);
		while (exp_due.size() > 0)
		begin
			@(negedge clk);
		end
		drive_idle(4);
	endtask

	task automatic check_idle_outputs();
		checks++;
		if (out_valid !== 1'b0)
		begin
			$display("CHECK FAILED at %0t: out_valid expected 0 got %b", $time, out_valid);
			errors++;
		end
		for (int k = 0; k < NK; k++)
		begin
			checks++;
			if (res[k] !== '0)
			begin
				$display("CHECK FAILED at %0t: %s expected 0 got %0d",
					$time, res_name[k], res[k]);
				errors++;
			end
		end
	endtask

	task automatic check_count(int expected);
		if (results_seen != expected)
		begin
			$display("expected %0d results but %0d arrived", expected, results_seen);
			errors++;
		end
	endtask

	task automatic report_test(string name, int e0);
		tests_run++;
		if (errors == e0)
		begin
			tests_ok++;
			$display("test %s: ok", name);
		end
		else
		begin
			$display("test %s: %0d errors", name, errors - e0);
		end
	endtask

	task automatic test_reset();
		int e0;
		e0 = errors;
		repeat (8)
		begin
			@(negedge clk);
			check_idle_outputs();
		end
		rst_n = 1'b1;
		repeat (3)
		begin
			@(negedge clk);
			check_idle_outputs();
		end
		report_test("reset", e0);
	endtask

	task automatic test_fill();
		int e0;
		int due;
		e0           = errors;
		first_valid  = -1;
		results_seen = 0;
		for (int i = 0; i < FILL + LINE_LEN; i++)
		begin
			drive_pixel(i);
		end
		wait_drain();
		// pixel 57 is the first one with seven lines behind it
		due = accept_cyc[FILL] + 2;
		if (first_valid != due)
		begin
			$display("first out_valid in cycle %0d, expected in cycle %0d", first_valid, due);
			errors++;
		end
		check_count(LINE_LEN);
		report_test("fill", e0);
	endtask

	// constant input, each held result is value times the kernel's coefficient sum
	task automatic test_flat(string name, int v);
		int e0;
		int want;
		e0           = errors;
		results_seen = 0;
		for (int i = 0; i < FILL + LINE_LEN; i++)
		begin
			drive_pixel(v);
		end
		wait_drain();
		for (int k = 0; k < NK; k++)
		begin
			want = v * coef_sum(k);
			checks++;
			if (int'(res[k]) != want)
			begin
				$display("CHECK FAILED at %0t: %s expected %0d got %0d",
					$time, res_name[k], want, res[k]);
				errors++;
			end
		end
		check_count(FILL + LINE_LEN);
		report_test(name, e0);
	endtask

	task automatic test_random();
		int e0;
		e0           = errors;
		results_seen = 0;
		for (int i = 0; i < 6 * LINE_LEN; i++)
		begin
			drive_pixel(int'($urandom_range(255, 0)));
		end
		wait_drain();
		check_count(6 * LINE_LEN);
		report_test("random image", e0);
	endtask

	task automatic test_paced();
		int e0;
		e0           = errors;
		results_seen = 0;
		for (int i = 0; i < 6 * LINE_LEN; i++)
		begin
			drive_idle(int'($urandom_range(3, 0)));
			drive_pixel(int'($urandom_range(255, 0)));
		end
		wait_drain();
		check_count(6 * LINE_LEN);
		report_test("paced input", e0);
	endtask

	initial
	begin
		rst_n    = 1'b0;
		new_data = 1'b0;
		pix_in   = '0;
		cycle    = 0;
		errors   = 0;
		checks   = 0;
		void'($urandom(27148));
		test_reset();
		test_fill();
		test_flat("flat field", int'($urandom_range(255, 1)));
		test_random();
		test_paced();
		test_flat("full scale", 255);
		$display("summary: %0d run, %0d ok, %0d checks, %0d errors",
			tests_run, tests_ok, checks, errors);
		if (errors == 0 && tests_ok == tests_run)
		begin
			$display("all tests passed");
		end
		else
		begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== hw/vfb_top.sv ====
module vfb_top #(
	parameter int LINE_LENGTH = vfb_geom_pkg::LINE_LENGTH_DEF
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           new_data,
	input  logic [vfb_geom_pkg::PIX_W-1:0] pix_in,
	output logic                           out_valid,
	output logic [vfb_coef_pkg::RES_W-1:0] res_f1,
	output logic [vfb_coef_pkg::RES_W-1:0] res_f2,
	output logic [vfb_coef_pkg::RES_W-1:0] res_f3,
	output logic [vfb_coef_pkg::RES_W-1:0] res_h1,
	output logic [vfb_coef_pkg::RES_W-1:0] res_h2,
	output logic [vfb_coef_pkg::RES_W-1:0] res_h3,
	output logic [vfb_coef_pkg::RES_W-1:0] res_h4
);

	column_if col_bus (
		.clk(clk)
	);

	column_window #(
		.LINE_LENGTH(LINE_LENGTH)
	) u_window (
		.clk     (clk),
		.rst_n   (rst_n),
		.new_data(new_data),
		.pix_in  (pix_in),
		.col     (col_bus.src)
	);

	// all kernels run in lockstep, f1 supplies the valid flag
	fltr_kernel #(.KERNEL(vfb_coef_pkg::K_F1)) u_f1 (
		.clk      (clk),
		.rst_n    (rst_n),
		.col      (col_bus.snk),
		.res      (res_f1),
		.out_valid(out_valid)
	);

	fltr_kernel #(.KERNEL(vfb_coef_pkg::K_F2)) u_f2 (
		.clk      (clk),
		.rst_n    (rst_n),
		.col      (col_bus.snk),
		.res      (res_f2),
		.out_valid()
	);

	fltr_kernel #(.KERNEL(vfb_coef_pkg::K_F3)) u_f3 (
		.clk      (clk),
		.rst_n    (rst_n),
		.col      (col_bus.snk),
		.res      (res_f3),
		.out_valid()
	);

	fltr_kernel #(.KERNEL(vfb_coef_pkg::K_H1)) u_h1 (
		.clk      (clk),
		.rst_n    (rst_n),
		.col      (col_bus.snk),
		.res      (res_h1),
		.out_valid()
	);

	fltr_kernel #(.KERNEL(vfb_coef_pkg::K_H2)) u_h2 (
		.clk      (clk),
		.rst_n    (rst_n),
		.col      (col_bus.snk),
		.res      (res_h2),
		.out_valid()
	);

	fltr_kernel #(.KERNEL(vfb_coef_pkg::K_H3)) u_h3 (
		.clk      (clk),
		.rst_n    (rst_n),
		.col      (col_bus.snk),
		.res      (res_h3),
		.out_valid()
	);

	fltr_kernel #(.KERNEL(vfb_coef_pkg::K_H4)) u_h4 (
		.clk      (clk),
		.rst_n    (rst_n),
		.col      (col_bus.snk),
		.res      (res_h4),
		.out_valid()
	);

endmodule

// ==== hw/fltr_kernel.sv ====
module fltr_kernel #(
	parameter int KERNEL = vfb_coef_pkg::K_F1
) (
	input  logic                           clk,
	input  logic                           rst_n,
	column_if.snk                          col,
	output logic [vfb_coef_pkg::RES_W-1:0] res,
	output logic                           out_valid
);

	localparam int TAPS   = vfb_geom_pkg::TAPS;
	localparam int RES_W  = vfb_coef_pkg::RES_W;
	localparam int PROD_W = vfb_geom_pkg::PIX_W + vfb_coef_pkg::COEF_W;

	logic [vfb_geom_pkg::PIX_W-1:0] rows [TAPS];
	logic [PROD_W-1:0]              prod_q [TAPS];
	logic                           valid_q;
	logic [RES_W-1:0]               sum;

	assign rows[0] = col.row0;
	assign rows[1] = col.row1;
	assign rows[2] = col.row2;
	assign rows[3] = col.row3;
	assign rows[4] = col.row4;
	assign rows[5] = col.row5;
	assign rows[6] = col.row6;

	// stage 1 products, loaded only with a live column
	always_ff @(posedge clk)
	begin
		if (col.col_valid)
		begin
			for (int t = 0; t < TAPS; t++)
			begin
				prod_q[t] <= PROD_W'(rows[t]) *
					PROD_W'(vfb_coef_pkg::KERNEL_COEF[KERNEL][t]);
			end
		end
	end

	// full-width adder tree, no truncation
	always_comb
	begin
		sum = '0;
		for (int t = 0; t < TAPS; t++)
		begin
			sum = sum + RES_W'(prod_q[t]);
		end
	end

	// stage 2, result holds between columns
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_q   <= 1'b0;
			out_valid <= 1'b0;
			res       <= '0;
		end
		else
		begin
			valid_q   <= col.col_valid;
			out_valid <= valid_q;
			if (valid_q)
			begin
				res <= sum;
			end
		end
	end

	a_two_stage: assert property (
		@(posedge col.clk) disable iff (!rst_n) out_valid == $past(col.col_valid, 2)
	);

endmodule

// ==== hw/column_window.sv ====
module column_window #(
	parameter int LINE_LENGTH = vfb_geom_pkg::LINE_LENGTH_DEF
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           new_data,
	input  logic [vfb_geom_pkg::PIX_W-1:0] pix_in,
	column_if.src                          col
);

	localparam int TAPS   = vfb_geom_pkg::TAPS;
	localparam int FILL   = TAPS * LINE_LENGTH;
	localparam int FILL_W = $clog2(FILL + 1);

	logic [vfb_geom_pkg::PIX_W-1:0] pix_q;
	logic [vfb_geom_pkg::PIX_W-1:0] line_out [TAPS];
	logic [FILL_W-1:0]              fill_cnt;

	// accepted pixel, feeds the head of the cascade
	always_ff @(posedge clk)
	begin
		if (new_data)
		begin
			pix_q <= pix_in;
		end
	end

	// one delay per row, so row k lags the pixel by k+1 lines
	for (genvar j = 0; j < TAPS; j++)
	begin : g_line
		logic [vfb_geom_pkg::PIX_W-1:0] line_in;

		if (j == 0)
		begin : g_head
			assign line_in = pix_q;
		end
		else
		begin : g_next
			assign line_in = line_out[j-1];
		end

		line_delay #(
			.LINE_LENGTH(LINE_LENGTH)
		) u_delay (
			.clk (clk),
			.en  (new_data),
			.din (line_in),
			.dout(line_out[j])
		);
	end

	assign col.row0 = line_out[0];
	assign col.row1 = line_out[1];
	assign col.row2 = line_out[2];
	assign col.row3 = line_out[3];
	assign col.row4 = line_out[4];
	assign col.row5 = line_out[5];
	assign col.row6 = line_out[6];

	// saturates once seven full lines are behind the incoming pixel
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			fill_cnt      <= '0;
			col.col_valid <= 1'b0;
		end
		else
		begin
			col.col_valid <= new_data && (fill_cnt == FILL_W'(FILL));
			if (new_data && (fill_cnt != FILL_W'(FILL)))
			begin
				fill_cnt <= fill_cnt + 1'b1;
			end
		end
	end

	a_valid_after_accept: assert property (
		@(posedge clk) disable iff (!rst_n) col.col_valid |-> $past(new_data)
	);

endmodule

// ==== hw/line_delay.sv ====
module line_delay #(
	parameter int LINE_LENGTH = vfb_geom_pkg::LINE_LENGTH_DEF
) (
	input  logic                           clk,
	input  logic                           en,
	input  logic [vfb_geom_pkg::PIX_W-1:0] din,
	output logic [vfb_geom_pkg::PIX_W-1:0] dout
);

	// oldest pixel sits at the far end
	logic [vfb_geom_pkg::PIX_W-1:0] shift_q [LINE_LENGTH];

	// slots that hold a defined pixel
	logic [LINE_LENGTH-1:0] known_q = '0;
	logic                   primed;

	always_ff @(posedge clk)
	begin
		if (en)
		begin
			shift_q[0] <= din;
			known_q[0] <= !$isunknown(din);
			for (int i = 1; i < LINE_LENGTH; i++)
			begin
				shift_q[i] <= shift_q[i-1];
				known_q[i] <= known_q[i-1];
			end
		end
	end

	// din from LINE_LENGTH accepted pixels back
	assign dout = shift_q[LINE_LENGTH-1];

	assign primed = known_q[LINE_LENGTH-1];

	// a defined pixel must survive the whole line intact
	a_dout_known: assert property (@(posedge clk) (en && primed) |-> !$isunknown(dout));

endmodule

// ==== hw/column_if.sv ====
interface column_if (
	input logic clk
);

	// single-cycle strobe, no ready
	logic col_valid;

	// row k entered k+1 lines before the current pixel
	logic [vfb_geom_pkg::PIX_W-1:0] row0;
	logic [vfb_geom_pkg::PIX_W-1:0] row1;
	logic [vfb_geom_pkg::PIX_W-1:0] row2;
	logic [vfb_geom_pkg::PIX_W-1:0] row3;
	logic [vfb_geom_pkg::PIX_W-1:0] row4;
	logic [vfb_geom_pkg::PIX_W-1:0] row5;
	logic [vfb_geom_pkg::PIX_W-1:0] row6;

	modport src (input clk, output col_valid, row0, row1, row2, row3, row4, row5, row6);
	modport snk (input clk, col_valid, row0, row1, row2, row3, row4, row5, row6);

endinterface

// ==== hw/vfb_coef_pkg.sv ====
package vfb_coef_pkg;

	// 7 x (8b * 8b) summed fits in 19 bits, one spare
	localparam int RES_W = 20;

	localparam int COEF_W = 8;

	localparam int NUM_KERNELS = 7;

	// kernel index names
	localparam int K_F1 = 0;
	localparam int K_F2 = 1;
	localparam int K_F3 = 2;
	localparam int K_H1 = 3;
	localparam int K_H2 = 4;
	localparam int K_H3 = 5;
	localparam int K_H4 = 6;

	// one row per kernel, taps 0 to 6
	// smoothing kernels first, then the band kernels
	localparam logic [COEF_W-1:0] KERNEL_COEF [NUM_KERNELS][vfb_geom_pkg::TAPS] = '{
		'{8'd29, 8'd101, 8'd15,  8'd235, 8'd15,  8'd101, 8'd29},
		'{8'd4,  8'd42,  8'd163, 8'd255, 8'd163, 8'd42,  8'd4},
		'{8'd12, 8'd77,  8'd148, 8'd0,   8'd148, 8'd77,  8'd12},
		'{8'd15, 8'd25,  8'd193, 8'd0,   8'd193, 8'd25,  8'd15},
		'{8'd4,  8'd42,  8'd163, 8'd255, 8'd163, 8'd42,  8'd4},
		'{8'd9,  8'd56,  8'd109, 8'd0,   8'd109, 8'd56,  8'd9},
		'{8'd9,  8'd56,  8'd109, 8'd0,   8'd109, 8'd56,  8'd9}
	};

endpackage

// ==== hw/vfb_geom_pkg.sv ====
package vfb_geom_pkg;

	// luminance sample width
	localparam int PIX_W = 8;

	// kernel length, also rows per column
	localparam int TAPS = 7;

	// pixels per video line unless the top level overrides it
	localparam int LINE_LENGTH_DEF = 496;

endpackage
